// ==== source/sdp_rdma_pkg.sv ====
/*
  shared widths, types and payload layouts for the sdp read dma ingress
  addresses and strides count 32-byte atoms, only the dma payload is in bytes
  request length fields hold the atom count minus one
*/
package sdp_rdma_pkg;

  // ====================================================================
  // widths
  // ====================================================================
  // one address unit is a 32-byte atom
  localparam int ATOM_SHIFT  = 5;
  localparam int ADDR_W      = 64;
  localparam int LINE_ADDR_W = ADDR_W - ATOM_SHIFT;
  localparam int STRIDE_W    = 27;
  localparam int DIM_W       = 13;
  localparam int SURF_CNT_W  = 9;
  localparam int LEN_W       = 15;
  localparam int STALL_W     = 32;

  // ====================================================================
  // plain vector types
  // ====================================================================
  typedef logic [DIM_W-1:0]       dim_t;
  typedef logic [SURF_CNT_W-1:0]  surf_cnt_t;
  // atoms per request, minus one
  typedef logic [LEN_W-1:0]       req_len_t;
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [STRIDE_W-1:0]    stride_t;
  typedef logic [ADDR_W-1:0]      byte_addr_t;
  typedef logic [STALL_W-1:0]     stall_cnt_t;

  // ====================================================================
  // enums
  // ====================================================================
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,
    PREC_INT16 = 2'd1,
    PREC_FP16  = 2'd2
  } proc_prec_e;

  typedef enum logic {
    WALK_IDLE = 1'b0,
    WALK_BUSY = 1'b1
  } walk_state_e;

  // ====================================================================
  // structs
  // ====================================================================
  // register block, held steady while a cube is walked
  typedef struct packed {
    logic        op_en;
    logic        perf_dma_en;
    proc_prec_e  proc_precision;
    // 0 = per kernel
    logic        data_mode;
    // 0 = 1 byte
    logic        data_size;
    // 2 = both
    logic [1:0]  data_use;
    dim_t        channel;
    dim_t        height;
    dim_t        width;
    logic [31:0] base_addr_high;
    stride_t     base_addr_low;
    stride_t     line_stride;
    stride_t     surface_stride;
  } rdma_cfg_t;

  // decoded cube shape
  typedef struct packed {
    req_len_t  req_len;
    surf_cnt_t last_surf;
    dim_t      last_line;
    logic      single_req;
  } cube_shape_t;

  // 79-bit read request, size above the byte address
  typedef struct packed {
    req_len_t   size;
    byte_addr_t addr;
  } dma_rd_req_t;

  // context queue entry, cube end on top
  typedef struct packed {
    logic     cube_end;
    req_len_t size;
  } cq_entry_t;

endpackage

// ==== source/sdp_rdma_cfg_decode.sv ====
/*
  combinational decode of the register block into the cube shape
  int16 with 1-byte data is not a legal setting, its length is undefined
  the clock input only samples the legality check
*/
`timescale 1ns/1ps

module sdp_rdma_cfg_decode (
  input  logic                      nvdla_core_clk,
  input  sdp_rdma_pkg::rdma_cfg_t   reg_cfg,
  output sdp_rdma_pkg::cube_shape_t shape
);

  // field decode
  logic cfg_proc_int8;
  logic cfg_proc_int16;
  logic cfg_size_1byte;
  logic cfg_use_both;
  logic cfg_per_kernel;
  logic cfg_1x1_pack;
  logic single_req;

  // atoms per element group, as a shift (m = 1, 2 or 4)
  logic [1:0] mul_shift;

  sdp_rdma_pkg::surf_cnt_t surf_cnt;
  sdp_rdma_pkg::dim_t      len_base;

  // one bit wider than the length field, n + 1 can reach 8192
  logic [sdp_rdma_pkg::LEN_W:0] len_plus1;
  logic [sdp_rdma_pkg::LEN_W:0] len_atoms;

  // ====================================================================
  // register fields
  // ====================================================================
  assign cfg_proc_int8  = (reg_cfg.proc_precision == sdp_rdma_pkg::PREC_INT8);
  assign cfg_proc_int16 = (reg_cfg.proc_precision == sdp_rdma_pkg::PREC_INT16);
  assign cfg_size_1byte = (reg_cfg.data_size == 1'b0);
  assign cfg_use_both   = (reg_cfg.data_use == 2'd2);
  assign cfg_per_kernel = (reg_cfg.data_mode == 1'b0);
  // 1x1 pack, whole cube is one straight run
  assign cfg_1x1_pack   = (reg_cfg.width == '0) && (reg_cfg.height == '0);
  assign single_req     = cfg_per_kernel || cfg_1x1_pack;

  // ====================================================================
  // surface count
  // ====================================================================
  // int8 packs 32 channels per atom, the others 16
  always_comb begin
    if (cfg_proc_int8) begin
      surf_cnt = {1'b0, reg_cfg.channel[12:5]};
    end else begin
      surf_cnt = reg_cfg.channel[12:4];
    end
  end

  // ====================================================================
  // length multiplier
  // ====================================================================
  always_comb begin
    if (cfg_proc_int8) begin
      if (cfg_use_both) begin
        // 2B or 4B per element
        mul_shift = cfg_size_1byte ? 2'd1 : 2'd2;
      end else begin
        mul_shift = cfg_size_1byte ? 2'd0 : 2'd1;
      end
    end else begin
      // int16 / fp16, data size does not change m
      mul_shift = cfg_use_both ? 2'd1 : 2'd0;
    end
  end

  // ====================================================================
  // request length, m x (n + 1) - 1
  // ====================================================================
  // straight run over surfaces, else one line of width
  assign len_base  = single_req ? {4'b0000, surf_cnt} : reg_cfg.width;
  assign len_plus1 = {{(sdp_rdma_pkg::LEN_W + 1 - sdp_rdma_pkg::DIM_W){1'b0}}, len_base}
                   + 1'b1;
  assign len_atoms = len_plus1 << mul_shift;

  assign shape.req_len    = sdp_rdma_pkg::req_len_t'(len_atoms - 1'b1);
  assign shape.last_surf  = surf_cnt;
  assign shape.last_line  = reg_cfg.height;
  assign shape.single_req = single_req;

  // ====================================================================
  // checks
  // ====================================================================
  // 1-byte data has no meaning for int16
  a_no_int16_1byte : assert property (
    @(posedge nvdla_core_clk)
    !(reg_cfg.op_en && cfg_proc_int16 && cfg_size_1byte)
  ) else $error("sdp rdma: 1-byte data size with int16 precision");

endmodule

// ==== source/sdp_rdma_cube_walk.sv ====
/*
  cube walker, lines advance first, then surfaces
  reg_cfg and shape must hold steady from op_load until the cube end accept
  one request outstanding at a time, steps only on cmd_accept
*/
`timescale 1ns/1ps

module sdp_rdma_cube_walk (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  sdp_rdma_pkg::rdma_cfg_t   reg_cfg,
  input  sdp_rdma_pkg::cube_shape_t shape,
  input  logic                      cmd_accept,
  output logic                      busy,
  output sdp_rdma_pkg::line_addr_t  line_addr,
  output logic                      cube_end
);

  sdp_rdma_pkg::walk_state_e state;

  // position in the cube
  sdp_rdma_pkg::surf_cnt_t count_c;
  sdp_rdma_pkg::dim_t      count_h;

  // current line, and start of the current surface
  sdp_rdma_pkg::line_addr_t base_addr_line;
  sdp_rdma_pkg::line_addr_t base_addr_surf;
  sdp_rdma_pkg::line_addr_t cfg_base_addr;

  // next addresses with carry on top
  logic [sdp_rdma_pkg::LINE_ADDR_W:0] line_step;
  logic [sdp_rdma_pkg::LINE_ADDR_W:0] surf_step;

  logic is_last_h;
  logic is_last_c;
  logic is_surf_end;

  // ====================================================================
  // busy state
  // ====================================================================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= sdp_rdma_pkg::WALK_IDLE;
    end else if (op_load) begin
      state <= sdp_rdma_pkg::WALK_BUSY;
    end else if (cmd_accept && cube_end) begin
      // last line taken
      state <= sdp_rdma_pkg::WALK_IDLE;
    end
  end

  assign busy = (state == sdp_rdma_pkg::WALK_BUSY);

  // ====================================================================
  // cube shape
  // ====================================================================
  assign is_last_h   = (count_h == shape.last_line);
  assign is_last_c   = (count_c == shape.last_surf);
  // single request covers the whole cube at once
  assign is_surf_end = shape.single_req || is_last_h;
  assign cube_end    = shape.single_req || (is_surf_end && is_last_c);

  // channel surfaces
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (op_load) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // lines within a surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (op_load) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (is_surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // ====================================================================
  // addresses
  // ====================================================================
  assign cfg_base_addr = {reg_cfg.base_addr_high, reg_cfg.base_addr_low};
  assign line_step     = {1'b0, base_addr_line} + reg_cfg.line_stride;
  assign surf_step     = {1'b0, base_addr_surf} + reg_cfg.surface_stride;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      base_addr_line <= '0;
      base_addr_surf <= '0;
    end else if (op_load) begin
      base_addr_line <= cfg_base_addr;
      base_addr_surf <= cfg_base_addr;
    end else if (cmd_accept) begin
      if (is_surf_end) begin
        // jump to the next surface start
        base_addr_line <= surf_step[sdp_rdma_pkg::LINE_ADDR_W-1:0];
        base_addr_surf <= surf_step[sdp_rdma_pkg::LINE_ADDR_W-1:0];
      end else begin
        base_addr_line <= line_step[sdp_rdma_pkg::LINE_ADDR_W-1:0];
      end
    end
  end

  assign line_addr = base_addr_line;

  // ====================================================================
  // checks
  // ====================================================================
  a_no_end_when_idle : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(cmd_accept && cube_end && !busy)
  ) else $error("sdp rdma: cube end accepted with no operation running");

  // stepped address must stay inside the 64-bit space
  a_no_addr_carry : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (cmd_accept && !cube_end) |->
      (is_surf_end ? !surf_step[sdp_rdma_pkg::LINE_ADDR_W]
                   : !line_step[sdp_rdma_pkg::LINE_ADDR_W])
  ) else $error("sdp rdma: address overflow while stepping");

endmodule

// ==== source/sdp_rdma_req_issue.sv ====
/*
  request issue, dma read and context queue move together
  each side is offered only while the other side is ready
  stall counter counts while op_en and perf_dma_en are both set
*/
`timescale 1ns/1ps

module sdp_rdma_req_issue (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  logic                      busy,
  input  logic                      cube_end,
  input  sdp_rdma_pkg::line_addr_t  line_addr,
  input  sdp_rdma_pkg::req_len_t    req_len,
  input  sdp_rdma_pkg::rdma_cfg_t   reg_cfg,
  output sdp_rdma_pkg::dma_rd_req_t dma_rd_req_pd,
  output logic                      dma_rd_req_vld,
  input  logic                      dma_rd_req_rdy,
  output sdp_rdma_pkg::cq_entry_t   ig2cq_pd,
  output logic                      ig2cq_pvld,
  input  logic                      ig2cq_prdy,
  output logic                      cmd_accept,
  output sdp_rdma_pkg::stall_cnt_t  dp2reg_rdma_stall
);

  logic stall_cnt_en;
  logic stall_cnt_inc;

  sdp_rdma_pkg::stall_cnt_t stall_cnt;

  // ====================================================================
  // handshake
  // ====================================================================
  // dma offered only when cq has room, and the reverse
  assign dma_rd_req_vld = busy && ig2cq_prdy;
  assign ig2cq_pvld     = busy && dma_rd_req_rdy;
  assign cmd_accept     = dma_rd_req_vld && dma_rd_req_rdy;

  // ====================================================================
  // payloads
  // ====================================================================
  // atom address back to bytes
  assign dma_rd_req_pd.addr = {line_addr, {sdp_rdma_pkg::ATOM_SHIFT{1'b0}}};
  assign dma_rd_req_pd.size = req_len;

  // same length goes to the egress side
  assign ig2cq_pd.size      = req_len;
  assign ig2cq_pd.cube_end  = cube_end;

  // ====================================================================
  // dma stall counter
  // ====================================================================
  assign stall_cnt_en  = reg_cfg.op_en && reg_cfg.perf_dma_en;
  assign stall_cnt_inc = dma_rd_req_vld && !dma_rd_req_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (stall_cnt_en) begin
      // new operation starts from zero
      if (op_load) begin
        stall_cnt <= '0;
      end else if (stall_cnt_inc) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

  assign dp2reg_rdma_stall = stall_cnt;

  // ====================================================================
  // checks
  // ====================================================================
  // a waiting request keeps its payload until both sides take it
  a_hold_payload : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (busy && !cmd_accept && !op_load) |=>
      ($stable(dma_rd_req_pd) && $stable(ig2cq_pd))
  ) else $error("sdp rdma: request payload moved before it was accepted");

endmodule

// ==== source/sdp_rdma_ig.sv ====
/*
  sdp read dma ingress, one read request per cube line
  reg_cfg must hold steady while a cube is in progress
  outputs are combinational from state and the two ready inputs
*/
`timescale 1ns/1ps

module sdp_rdma_ig (
  input  logic                      nvdla_core_clk,
  input  logic                      nvdla_core_rstn,
  input  logic                      op_load,
  input  sdp_rdma_pkg::rdma_cfg_t   reg_cfg,
  // dma read request
  output sdp_rdma_pkg::dma_rd_req_t dma_rd_req_pd,
  output logic                      dma_rd_req_vld,
  input  logic                      dma_rd_req_rdy,
  // context queue
  output sdp_rdma_pkg::cq_entry_t   ig2cq_pd,
  output logic                      ig2cq_pvld,
  input  logic                      ig2cq_prdy,
  // perf
  output sdp_rdma_pkg::stall_cnt_t  dp2reg_rdma_stall
);

  sdp_rdma_pkg::cube_shape_t shape;
  sdp_rdma_pkg::line_addr_t  line_addr;

  logic busy;
  logic cube_end;
  logic cmd_accept;

  // ====================================================================
  // decode
  // ====================================================================
  sdp_rdma_cfg_decode u_decode (
    .nvdla_core_clk (nvdla_core_clk),
    .reg_cfg        (reg_cfg),
    .shape          (shape)
  );

  // ====================================================================
  // cube walk
  // ====================================================================
  sdp_rdma_cube_walk u_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .reg_cfg         (reg_cfg),
    .shape           (shape),
    .cmd_accept      (cmd_accept),
    .busy            (busy),
    .line_addr       (line_addr),
    .cube_end        (cube_end)
  );

  // ====================================================================
  // request issue
  // ====================================================================
  sdp_rdma_req_issue u_issue (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .op_load           (op_load),
    .busy              (busy),
    .cube_end          (cube_end),
    .line_addr         (line_addr),
    .req_len           (shape.req_len),
    .reg_cfg           (reg_cfg),
    .dma_rd_req_pd     (dma_rd_req_pd),
    .dma_rd_req_vld    (dma_rd_req_vld),
    .dma_rd_req_rdy    (dma_rd_req_rdy),
    .ig2cq_pd          (ig2cq_pd),
    .ig2cq_pvld        (ig2cq_pvld),
    .ig2cq_prdy        (ig2cq_prdy),
    .cmd_accept        (cmd_accept),
    .dp2reg_rdma_stall (dp2reg_rdma_stall)
  );

endmodule

// ==== testbench/tb_sdp_rdma_ig.sv ====
/*
  table-driven testbench for the sdp read dma ingress
  expected requests come from a model of the cube walk and length rules
  readies are random on back-pressure rows, otherwise held high
  int16 with 1-byte data is never configured
*/
`timescale 1ns/1ps

module tb_sdp_rdma_ig;

  localparam int NUM_CASES = 11;

  logic                      nvdla_core_clk;
  logic                      nvdla_core_rstn;
  logic                      op_load;
  sdp_rdma_pkg::rdma_cfg_t   reg_cfg;
  sdp_rdma_pkg::dma_rd_req_t dma_rd_req_pd;
  logic                      dma_rd_req_vld;
  logic                      dma_rd_req_rdy;
  sdp_rdma_pkg::cq_entry_t   ig2cq_pd;
  logic                      ig2cq_pvld;
  logic                      ig2cq_prdy;
  sdp_rdma_pkg::stall_cnt_t  dp2reg_rdma_stall;

  // case table
  sdp_rdma_pkg::rdma_cfg_t case_cfg [NUM_CASES];
  logic                    case_bp  [NUM_CASES];
  int                      case_reqs[NUM_CASES];
  logic                    table_ready;

  // expected request list of the current case
  logic [63:0]            exp_addr[$];
  sdp_rdma_pkg::req_len_t exp_len[$];
  logic                   exp_end[$];

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          accepts;
  int          cur_case;

  sdp_rdma_ig DUT (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .op_load           (op_load),
    .reg_cfg           (reg_cfg),
    .dma_rd_req_pd     (dma_rd_req_pd),
    .dma_rd_req_vld    (dma_rd_req_vld),
    .dma_rd_req_rdy    (dma_rd_req_rdy),
    .ig2cq_pd          (ig2cq_pd),
    .ig2cq_pvld        (ig2cq_pvld),
    .ig2cq_prdy        (ig2cq_prdy),
    .dp2reg_rdma_stall (dp2reg_rdma_stall)
  );

  // 4 ns period
  always #2 nvdla_core_clk = ~nvdla_core_clk;

  // ====================================================================
  // helpers
  // ====================================================================
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic sdp_rdma_pkg::rdma_cfg_t make_cfg(
    input sdp_rdma_pkg::proc_prec_e prec, input logic mode, input logic size,
    input logic [1:0] use_sel, input int chan, input int height, input int width,
    input logic perf, input logic [31:0] base_hi, input int base_lo,
    input int line_stride, input int surf_stride);
    sdp_rdma_pkg::rdma_cfg_t cfg;
    cfg                = '0;
    cfg.op_en          = 1'b1;
    cfg.perf_dma_en    = perf;
    cfg.proc_precision = prec;
    cfg.data_mode      = mode;
    cfg.data_size      = size;
    cfg.data_use       = use_sel;
    cfg.channel        = sdp_rdma_pkg::dim_t'(chan);
    cfg.height         = sdp_rdma_pkg::dim_t'(height);
    cfg.width          = sdp_rdma_pkg::dim_t'(width);
    cfg.base_addr_high = base_hi;
    cfg.base_addr_low  = sdp_rdma_pkg::stride_t'(base_lo);
    cfg.line_stride    = sdp_rdma_pkg::stride_t'(line_stride);
    cfg.surface_stride = sdp_rdma_pkg::stride_t'(surf_stride);
    return cfg;
  endfunction

  // reference model, fills the expected queues
  task automatic build_expect(input sdp_rdma_pkg::rdma_cfg_t cfg);
    int          sc;
    int          m;
    int          n;
    int          len;
    logic        single;
    logic        is_int8;
    logic [63:0] base;
    logic [63:0] la;
    exp_addr.delete();
    exp_len.delete();
    exp_end.delete();
    is_int8 = (cfg.proc_precision == sdp_rdma_pkg::PREC_INT8);
    sc      = is_int8 ? int'(cfg.channel) / 32 : int'(cfg.channel) / 16;
    // atoms per element group
    if (is_int8 && cfg.data_use == 2'd2) begin
      m = cfg.data_size ? 4 : 2;
    end else if (is_int8) begin
      m = cfg.data_size ? 2 : 1;
    end else begin
      m = (cfg.data_use == 2'd2) ? 2 : 1;
    end
    single = (cfg.data_mode == 1'b0) || (cfg.width == 0 && cfg.height == 0);
    n      = single ? sc : int'(cfg.width);
    len    = m * (n + 1) - 1;
    base   = {5'b0, cfg.base_addr_high, cfg.base_addr_low};
    if (single) begin
      exp_addr.push_back(base << 5);
      exp_len.push_back(sdp_rdma_pkg::req_len_t'(len));
      exp_end.push_back(1'b1);
    end else begin
      for (int c = 0; c <= sc; c++) begin
        for (int h = 0; h <= int'(cfg.height); h++) begin
          la = base + c * cfg.surface_stride + h * cfg.line_stride;
          exp_addr.push_back(la << 5);
          exp_len.push_back(sdp_rdma_pkg::req_len_t'(len));
          exp_end.push_back(c == sc && h == int'(cfg.height));
        end
      end
    end
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("mismatch case %0d req %0d %s got 0x%h exp 0x%h",
               cur_case, accepts, name, got, exp);
    end
  endtask

  task automatic check_valids_low(input string where);
    checks++;
    assert (!dma_rd_req_vld && !ig2cq_pvld) else begin
      errors++;
      $display("case %0d: a valid was high %s", cur_case, where);
    end
  endtask

  task automatic drive_readies(input logic bp);
    if (bp) begin
      lfsr           = lfsr_next(lfsr);
      dma_rd_req_rdy = lfsr[0];
      lfsr           = lfsr_next(lfsr);
      ig2cq_prdy     = lfsr[0];
    end else begin
      dma_rd_req_rdy = 1'b1;
      ig2cq_prdy     = 1'b1;
    end
  endtask

  // ====================================================================
  // case table
  // ====================================================================
  task automatic build_table();
    // int8 / int16 line walks, fp16, int8 multipliers, single modes, fp16 1-byte
    case_cfg[0] = make_cfg(sdp_rdma_pkg::PREC_INT8, 1'b1, 1'b0, 2'd1, 63, 2, 7,
                           1'b1, 32'h1, 'h40, 'h10, 'h100);
    case_cfg[1] = make_cfg(sdp_rdma_pkg::PREC_INT16, 1'b1, 1'b1, 2'd2, 47, 3, 3,
                           1'b1, 32'h0, 'h1000, 'h20, 'h400);
    case_cfg[2] = make_cfg(sdp_rdma_pkg::PREC_FP16, 1'b1, 1'b1, 2'd1, 15, 1, 10,
                           1'b0, 32'h7, 'h3, 'h8, 'h80);
    case_cfg[3] = make_cfg(sdp_rdma_pkg::PREC_INT8, 1'b1, 1'b1, 2'd2, 31, 1, 5,
                           1'b1, 32'h0, 'h200, 'h30, 'h200);
    case_cfg[4] = make_cfg(sdp_rdma_pkg::PREC_INT8, 1'b1, 1'b1, 2'd1, 40, 2, 2,
                           1'b1, 32'h2, 'h0, 'h4, 'h40);
    case_cfg[5] = make_cfg(sdp_rdma_pkg::PREC_INT8, 1'b1, 1'b0, 2'd2, 70, 1, 1,
                           1'b1, 32'h0, 'h7ff_ff00, 'h11, 'h35);
    case_cfg[6] = make_cfg(sdp_rdma_pkg::PREC_INT8, 1'b0, 1'b0, 2'd1, 95, 4, 9,
                           1'b1, 32'h5, 'h100, 'h10, 'h100);
    case_cfg[7] = make_cfg(sdp_rdma_pkg::PREC_FP16, 1'b1, 1'b1, 2'd2, 63, 0, 0,
                           1'b1, 32'h0, 'h60, 'h10, 'h100);
    case_cfg[8] = make_cfg(sdp_rdma_pkg::PREC_INT16, 1'b1, 1'b1, 2'd1, 33, 2, 4,
                           1'b1, 32'hffff_0000, 'h10, 'h40, 'h1000);
    case_cfg[9] = make_cfg(sdp_rdma_pkg::PREC_FP16, 1'b1, 1'b0, 2'd1, 36, 1, 6,
                           1'b1, 32'h3, 'h500, 'h18, 'h90);
    case_cfg[10] = make_cfg(sdp_rdma_pkg::PREC_FP16, 1'b1, 1'b0, 2'd2, 17, 2, 12,
                            1'b1, 32'h0, 'h20, 'h28, 'h100);
    case_bp = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
    for (int i = 0; i < NUM_CASES; i++) begin
      build_expect(case_cfg[i]);
      case_reqs[i] = exp_addr.size();
    end
    table_ready = 1'b1;
  endtask

  // ====================================================================
  // one cube
  // ====================================================================
  task automatic run_case(input int idx);
    sdp_rdma_pkg::rdma_cfg_t  cfg;
    sdp_rdma_pkg::stall_cnt_t stall_exp;
    logic                     got_end;
    logic                     dma_acc;
    logic                     cq_acc;
    cfg       = case_cfg[idx];
    cur_case  = idx;
    accepts   = 0;
    got_end   = 1'b0;
    build_expect(cfg);
    // counter frozen when perf is off
    stall_exp = cfg.perf_dma_en ? '0 : dp2reg_rdma_stall;
    @(posedge nvdla_core_clk);
    #1;
    reg_cfg = cfg;
    op_load = 1'b1;
    drive_readies(case_bp[idx]);
    @(negedge nvdla_core_clk);
    check_valids_low("in the op_load cycle");
    while (!got_end) begin
      @(posedge nvdla_core_clk);
      #1;
      op_load = 1'b0;
      drive_readies(case_bp[idx]);
      @(negedge nvdla_core_clk);
      dma_acc = dma_rd_req_vld && dma_rd_req_rdy;
      cq_acc  = ig2cq_pvld && ig2cq_prdy;
      // busy for the whole loop, each valid follows the other side's ready
      compare_value("dma_rd_req_vld", dma_rd_req_vld, ig2cq_prdy);
      compare_value("ig2cq_pvld", ig2cq_pvld, dma_rd_req_rdy);
      checks++;
      assert (dma_acc == cq_acc) else begin
        errors++;
        $display("case %0d: dma accept and context queue push apart", idx);
      end
      if (ig2cq_prdy && !dma_rd_req_rdy && cfg.perf_dma_en) begin
        stall_exp++;
      end
      if (dma_acc && exp_addr.size() == 0) begin
        errors++;
        $display("case %0d: more requests issued than expected", idx);
        got_end = 1'b1;
      end else if (dma_acc) begin
        compare_value("dma_rd_req_pd.addr", dma_rd_req_pd.addr, exp_addr.pop_front());
        compare_value("dma_rd_req_pd.size", dma_rd_req_pd.size, exp_len[0]);
        compare_value("ig2cq_pd.size", ig2cq_pd.size, exp_len.pop_front());
        compare_value("ig2cq_pd.cube_end", ig2cq_pd.cube_end, exp_end.pop_front());
        accepts++;
        got_end = ig2cq_pd.cube_end;
      end
    end
    checks++;
    assert (exp_addr.size() == 0) else begin
      errors++;
      $display("case %0d: cube ended with %0d requests missing", idx, exp_addr.size());
    end
    // idle tail, readies high so a stray request would show
    repeat (4) begin
      @(posedge nvdla_core_clk);
      #1;
      drive_readies(1'b0);
      @(negedge nvdla_core_clk);
      check_valids_low("after the cube end");
    end
    compare_value("dp2reg_rdma_stall", dp2reg_rdma_stall, stall_exp);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    op_load         = 1'b0;
    reg_cfg         = '0;
    dma_rd_req_rdy  = 1'b1;
    ig2cq_prdy      = 1'b1;
    lfsr            = 32'hcc19de0f;
    errors          = 0;
    checks          = 0;
    accepts         = 0;
    cur_case        = -1;
    table_ready     = 1'b0;
    build_table();
    repeat (10) begin
      @(negedge nvdla_core_clk);
      check_valids_low("during reset");
      compare_value("dp2reg_rdma_stall", dp2reg_rdma_stall, '0);
    end
    @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    @(negedge nvdla_core_clk);
    check_valids_low("just after reset");
    compare_value("dp2reg_rdma_stall", dp2reg_rdma_stall, '0);
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end
    $display("cases %0d checks %0d errors %0d", NUM_CASES, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // budget of 8 cycles per request plus per-case overhead
  initial begin : watchdog
    int budget;
    wait (table_ready);
    budget = 200;
    for (int i = 0; i < NUM_CASES; i++) begin
      budget += case_reqs[i] * 8 + 8;
    end
    #(budget * 4);
    $display("watchdog timeout after %0d cycles, case %0d did not finish", budget, cur_case);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== sources.f ====
source/sdp_rdma_pkg.sv
source/sdp_rdma_cfg_decode.sv
source/sdp_rdma_cube_walk.sv
source/sdp_rdma_req_issue.sv
source/sdp_rdma_ig.sv
testbench/tb_sdp_rdma_ig.sv

// ==== Makefile ====
TOP := tb_sdp_rdma_ig

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "=== PASS ==="

clean:
	rm -rf obj_dir
